// ==== common/uart_reg_pkg.sv ====
package uart_reg_pkg;

	localparam int UART_REG_AW = 6;
	localparam int UART_REG_DW = 32;
	localparam int UART_REG_NUM = 8;

	localparam logic [UART_REG_AW-1:0] UART_INTR_STATE_OFFSET = 6'h00;
	localparam logic [UART_REG_AW-1:0] UART_INTR_ENABLE_OFFSET = 6'h04;
	localparam logic [UART_REG_AW-1:0] UART_INTR_TEST_OFFSET = 6'h08;
	localparam logic [UART_REG_AW-1:0] UART_CTRL_OFFSET = 6'h0c;
	localparam logic [UART_REG_AW-1:0] UART_STATUS_OFFSET = 6'h10;
	localparam logic [UART_REG_AW-1:0] UART_RDATA_OFFSET = 6'h14;
	localparam logic [UART_REG_AW-1:0] UART_WDATA_OFFSET = 6'h18;
	localparam logic [UART_REG_AW-1:0] UART_FIFO_CTRL_OFFSET = 6'h1c;

	localparam int UART_IDX_INTR_STATE = 0;
	localparam int UART_IDX_INTR_ENABLE = 1;
	localparam int UART_IDX_INTR_TEST = 2;
	localparam int UART_IDX_CTRL = 3;
	localparam int UART_IDX_STATUS = 4;
	localparam int UART_IDX_RDATA = 5;
	localparam int UART_IDX_WDATA = 6;
	localparam int UART_IDX_FIFO_CTRL = 7;

	// byte enables each register needs, index 7 leftmost.
	localparam logic [UART_REG_NUM-1:0][3:0] UART_PERMIT = {
		4'b0001, 4'b0001, 4'b0001, 4'b0001,
		4'b1111, 4'b0001, 4'b0001, 4'b0001
	};

	typedef struct packed {
		logic we;
		logic re;
		logic [UART_REG_AW-1:0] addr;
		logic [UART_REG_DW-1:0] wdata;
		logic [UART_REG_DW/8-1:0] be;
	} uart_reg_req_t;

	typedef struct packed {
		logic [UART_REG_DW-1:0] rdata;
		logic error;
	} uart_reg_rsp_t;

	// tx_watermark sits in bit 0.
	typedef struct packed {
		logic rx_parity_err;
		logic rx_timeout;
		logic rx_break_err;
		logic rx_frame_err;
		logic rx_overflow;
		logic tx_empty;
		logic rx_watermark;
		logic tx_watermark;
	} uart_intr_t;

	typedef struct packed {
		logic [15:0] nco;
		logic [5:0] rsvd1;
		logic [1:0] rxblvl;
		logic parity_odd;
		logic parity_en;
		logic llpbk;
		logic slpbk;
		logic rsvd0;
		logic nf;
		logic rx;
		logic tx;
	} uart_ctrl_t;

	typedef struct packed {
		logic [1:0] txilvl;
		logic [2:0] rxilvl;
		logic txrst;
		logic rxrst;
	} uart_fifo_ctrl_t;

	typedef struct packed {
		logic [23:0] rsvd;
		uart_intr_t bits;
	} uart_intr_word_t;

	typedef struct packed {
		logic [24:0] rsvd;
		uart_fifo_ctrl_t bits;
	} uart_fifo_word_t;

	typedef union packed {
		logic [UART_REG_DW-1:0] raw;
		uart_ctrl_t ctrl;
		uart_intr_word_t intr;
		uart_fifo_word_t fifo;
	} uart_wdata_u;

	typedef struct packed {
		logic rxempty;
		logic rxidle;
		logic txidle;
		logic txempty;
		logic rxfull;
		logic txfull;
	} uart_status_t;

	typedef struct packed {
		logic [UART_REG_NUM-1:0] we;
		logic [UART_REG_NUM-1:0] re;
	} uart_reg_strb_t;

	typedef struct packed {
		uart_intr_t state;
		uart_intr_t enable;
		uart_intr_t test;
		logic test_qe;
	} uart_intr_reg2hw_t;

	typedef struct packed {
		uart_intr_t d;
		uart_intr_t de;
	} uart_intr_hw2reg_t;

	typedef struct packed {
		logic tx;
		logic rx;
		logic nf;
		logic slpbk;
		logic llpbk;
		logic parity_en;
		logic parity_odd;
		logic [1:0] rxblvl;
		logic [15:0] nco;
		logic [7:0] wdata;
		logic wdata_qe;
		logic rxrst;
		logic rxrst_qe;
		logic txrst;
		logic txrst_qe;
		logic [2:0] rxilvl;
		logic [1:0] txilvl;
		logic rdata_re;
		logic status_re;
	} uart_ctrl_reg2hw_t;

	typedef struct packed {
		uart_status_t status;
		logic [7:0] rdata;
		logic [2:0] rxilvl;
		logic rxilvl_de;
		logic [1:0] txilvl;
		logic txilvl_de;
	} uart_ctrl_hw2reg_t;

endpackage

// ==== source/uart_reg_decode.sv ====
`timescale 1ns/1ps

module uart_reg_decode (
	input uart_reg_pkg::uart_reg_req_t bus_req_i,
	output uart_reg_pkg::uart_reg_strb_t strb_o,
	output logic [uart_reg_pkg::UART_REG_NUM-1:0] addr_hit_o,
	output logic error_o
);
	import uart_reg_pkg::*;

	logic addr_miss;
	logic wr_err;

	always_comb begin
		addr_hit_o = '0;
		addr_hit_o[UART_IDX_INTR_STATE] = bus_req_i.addr == UART_INTR_STATE_OFFSET;
		addr_hit_o[UART_IDX_INTR_ENABLE] = bus_req_i.addr == UART_INTR_ENABLE_OFFSET;
		addr_hit_o[UART_IDX_INTR_TEST] = bus_req_i.addr == UART_INTR_TEST_OFFSET;
		addr_hit_o[UART_IDX_CTRL] = bus_req_i.addr == UART_CTRL_OFFSET;
		addr_hit_o[UART_IDX_STATUS] = bus_req_i.addr == UART_STATUS_OFFSET;
		addr_hit_o[UART_IDX_RDATA] = bus_req_i.addr == UART_RDATA_OFFSET;
		addr_hit_o[UART_IDX_WDATA] = bus_req_i.addr == UART_WDATA_OFFSET;
		addr_hit_o[UART_IDX_FIFO_CTRL] = bus_req_i.addr == UART_FIFO_CTRL_OFFSET;
	end

	assign addr_miss = (bus_req_i.we | bus_req_i.re) & ~|addr_hit_o;

	// a write must cover every byte the register needs.
	always_comb begin
		wr_err = 1'b0;
		for (int i = 0; i < UART_REG_NUM; i++) begin
			if (addr_hit_o[i] && bus_req_i.we && ((UART_PERMIT[i] & ~bus_req_i.be) != '0)) begin
				wr_err = 1'b1;
			end
		end
	end

	assign error_o = addr_miss | wr_err;

	assign strb_o.we = addr_hit_o & {UART_REG_NUM{bus_req_i.we & ~wr_err}};
	assign strb_o.re = addr_hit_o & {UART_REG_NUM{bus_req_i.re}};

endmodule

// ==== source/uart_reg_readback.sv ====
`timescale 1ns/1ps

module uart_reg_readback (
	input logic [uart_reg_pkg::UART_REG_NUM-1:0] addr_hit_i,
	input uart_reg_pkg::uart_intr_t intr_state_i,
	input uart_reg_pkg::uart_intr_t intr_enable_i,
	input uart_reg_pkg::uart_ctrl_t ctrl_i,
	input uart_reg_pkg::uart_fifo_ctrl_t fifo_ctrl_i,
	input uart_reg_pkg::uart_status_t status_i,
	input logic [7:0] rdata_i,
	output logic [uart_reg_pkg::UART_REG_DW-1:0] rdata_o
);
	import uart_reg_pkg::*;

	uart_fifo_ctrl_t fifo_rd;

	// reset bits are write only.
	always_comb begin
		fifo_rd = fifo_ctrl_i;
		fifo_rd.rxrst = 1'b0;
		fifo_rd.txrst = 1'b0;
	end

	always_comb begin
		rdata_o = '0;
		case (1'b1)
			addr_hit_i[UART_IDX_INTR_STATE]: rdata_o[7:0] = intr_state_i;
			addr_hit_i[UART_IDX_INTR_ENABLE]: rdata_o[7:0] = intr_enable_i;
			addr_hit_i[UART_IDX_INTR_TEST]: rdata_o = '0;
			addr_hit_i[UART_IDX_CTRL]: rdata_o = ctrl_i;
			addr_hit_i[UART_IDX_STATUS]: rdata_o[5:0] = status_i;
			addr_hit_i[UART_IDX_RDATA]: rdata_o[7:0] = rdata_i;
			addr_hit_i[UART_IDX_WDATA]: rdata_o = '0;
			addr_hit_i[UART_IDX_FIFO_CTRL]: rdata_o[6:0] = fifo_rd;
			// unmapped.
			default: rdata_o = '1;
		endcase
	end

endmodule

// ==== source/uart_intr_regs.sv ====
`timescale 1ns/1ps

module uart_intr_regs (
	input logic clk_i,
	input logic rst_n_i,
	input uart_reg_pkg::uart_reg_strb_t strb_i,
	input uart_reg_pkg::uart_wdata_u wdata_i,
	input uart_reg_pkg::uart_intr_hw2reg_t hw2reg_i,
	output uart_reg_pkg::uart_intr_reg2hw_t reg2hw_o,
	output uart_reg_pkg::uart_intr_t state_o,
	output uart_reg_pkg::uart_intr_t enable_o
);
	import uart_reg_pkg::*;

	uart_intr_t state_q;
	uart_intr_t enable_q;
	uart_intr_t sw_clr;
	logic test_we;

	assign sw_clr = strb_i.we[UART_IDX_INTR_STATE] ? wdata_i.intr.bits : '0;
	assign test_we = strb_i.we[UART_IDX_INTR_TEST];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= '0;
			enable_q <= '0;
		end else begin
			// hardware update wins over a software clear.
			state_q <= (hw2reg_i.de & hw2reg_i.d) | (~hw2reg_i.de & state_q & ~sw_clr);
			if (strb_i.we[UART_IDX_INTR_ENABLE]) begin
				enable_q <= wdata_i.intr.bits;
			end
		end
	end

	assign state_o = state_q;
	assign enable_o = enable_q;

	assign reg2hw_o.state = state_q;
	assign reg2hw_o.enable = enable_q;
	// test fields live only in the write cycle.
	assign reg2hw_o.test = test_we ? wdata_i.intr.bits : '0;
	assign reg2hw_o.test_qe = test_we;

endmodule

// ==== source/uart_ctrl_regs.sv ====
`timescale 1ns/1ps

module uart_ctrl_regs (
	input logic clk_i,
	input logic rst_n_i,
	input uart_reg_pkg::uart_reg_strb_t strb_i,
	input uart_reg_pkg::uart_wdata_u wdata_i,
	input uart_reg_pkg::uart_ctrl_hw2reg_t hw2reg_i,
	output uart_reg_pkg::uart_ctrl_reg2hw_t reg2hw_o,
	output uart_reg_pkg::uart_ctrl_t ctrl_o,
	output uart_reg_pkg::uart_fifo_ctrl_t fifo_ctrl_o
);
	import uart_reg_pkg::*;

	uart_ctrl_t ctrl_q;
	uart_ctrl_t ctrl_wd;
	uart_fifo_ctrl_t fifo_q;
	logic [7:0] wdata_q;
	logic wdata_qe;
	logic fifo_qe;
	logic fifo_we;

	always_comb begin
		ctrl_wd = wdata_i.ctrl;
		ctrl_wd.rsvd0 = 1'b0;
		ctrl_wd.rsvd1 = '0;
	end

	assign fifo_we = strb_i.we[UART_IDX_FIFO_CTRL];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_q <= '0;
			fifo_q <= '0;
			wdata_q <= '0;
			wdata_qe <= 1'b0;
			fifo_qe <= 1'b0;
		end else begin
			if (strb_i.we[UART_IDX_CTRL]) begin
				ctrl_q <= ctrl_wd;
			end
			if (strb_i.we[UART_IDX_WDATA]) begin
				wdata_q <= wdata_i.raw[7:0];
			end
			wdata_qe <= strb_i.we[UART_IDX_WDATA];
			fifo_qe <= fifo_we;
			if (fifo_we) begin
				fifo_q.rxrst <= wdata_i.fifo.bits.rxrst;
				fifo_q.txrst <= wdata_i.fifo.bits.txrst;
			end
			// levels take a hardware load first.
			if (hw2reg_i.rxilvl_de) begin
				fifo_q.rxilvl <= hw2reg_i.rxilvl;
			end else if (fifo_we) begin
				fifo_q.rxilvl <= wdata_i.fifo.bits.rxilvl;
			end
			if (hw2reg_i.txilvl_de) begin
				fifo_q.txilvl <= hw2reg_i.txilvl;
			end else if (fifo_we) begin
				fifo_q.txilvl <= wdata_i.fifo.bits.txilvl;
			end
		end
	end

	assign ctrl_o = ctrl_q;
	assign fifo_ctrl_o = fifo_q;

	assign reg2hw_o.tx = ctrl_q.tx;
	assign reg2hw_o.rx = ctrl_q.rx;
	assign reg2hw_o.nf = ctrl_q.nf;
	assign reg2hw_o.slpbk = ctrl_q.slpbk;
	assign reg2hw_o.llpbk = ctrl_q.llpbk;
	assign reg2hw_o.parity_en = ctrl_q.parity_en;
	assign reg2hw_o.parity_odd = ctrl_q.parity_odd;
	assign reg2hw_o.rxblvl = ctrl_q.rxblvl;
	assign reg2hw_o.nco = ctrl_q.nco;
	assign reg2hw_o.wdata = wdata_q;
	assign reg2hw_o.wdata_qe = wdata_qe;
	assign reg2hw_o.rxrst = fifo_q.rxrst;
	assign reg2hw_o.rxrst_qe = fifo_qe;
	assign reg2hw_o.txrst = fifo_q.txrst;
	assign reg2hw_o.txrst_qe = fifo_qe;
	assign reg2hw_o.rxilvl = fifo_q.rxilvl;
	assign reg2hw_o.txilvl = fifo_q.txilvl;
	// read side effects for the core.
	assign reg2hw_o.rdata_re = strb_i.re[UART_IDX_RDATA];
	assign reg2hw_o.status_re = strb_i.re[UART_IDX_STATUS];

endmodule

// ==== source/uart_reg_top.sv ====
`timescale 1ns/1ps

module uart_reg_top (
	input logic clk_i,
	input logic rst_n_i,
	input uart_reg_pkg::uart_reg_req_t bus_req_i,
	output uart_reg_pkg::uart_reg_rsp_t bus_rsp_o,
	input uart_reg_pkg::uart_intr_hw2reg_t intr_hw2reg_i,
	output uart_reg_pkg::uart_intr_reg2hw_t intr_reg2hw_o,
	input uart_reg_pkg::uart_ctrl_hw2reg_t ctrl_hw2reg_i,
	output uart_reg_pkg::uart_ctrl_reg2hw_t ctrl_reg2hw_o
);
	import uart_reg_pkg::*;

	uart_reg_strb_t strb;
	logic [UART_REG_NUM-1:0] addr_hit;
	logic rsp_error;
	logic [UART_REG_DW-1:0] rsp_rdata;
	uart_intr_t intr_state;
	uart_intr_t intr_enable;
	uart_ctrl_t ctrl;
	uart_fifo_ctrl_t fifo_ctrl;

	assign bus_rsp_o = '{rdata: rsp_rdata, error: rsp_error};

	uart_reg_decode i_decode (
		.bus_req_i (bus_req_i),
		.strb_o (strb),
		.addr_hit_o (addr_hit),
		.error_o (rsp_error)
	);

	uart_intr_regs i_intr_regs (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.strb_i (strb),
		.wdata_i (bus_req_i.wdata),
		.hw2reg_i (intr_hw2reg_i),
		.reg2hw_o (intr_reg2hw_o),
		.state_o (intr_state),
		.enable_o (intr_enable)
	);

	uart_ctrl_regs i_ctrl_regs (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.strb_i (strb),
		.wdata_i (bus_req_i.wdata),
		.hw2reg_i (ctrl_hw2reg_i),
		.reg2hw_o (ctrl_reg2hw_o),
		.ctrl_o (ctrl),
		.fifo_ctrl_o (fifo_ctrl)
	);

	// status and rdata come straight from the core.
	uart_reg_readback i_readback (
		.addr_hit_i (addr_hit),
		.intr_state_i (intr_state),
		.intr_enable_i (intr_enable),
		.ctrl_i (ctrl),
		.fifo_ctrl_i (fifo_ctrl),
		.status_i (ctrl_hw2reg_i.status),
		.rdata_i (ctrl_hw2reg_i.rdata),
		.rdata_o (rsp_rdata)
	);

endmodule

// ==== sim/uart_reg_tests.svh ====
task automatic after_reset_defaults();
	int errs;
	errs = err_cnt;
	check_value("intr_reg2hw_o", 64'(intr_r2h), 64'h0);
	check_value("ctrl_reg2hw_o", 64'(ctrl_r2h), 64'h0);
	read_expect(UART_INTR_STATE_OFFSET, 32'h0, "intr_state");
	read_expect(UART_INTR_ENABLE_OFFSET, 32'h0, "intr_enable");
	read_expect(UART_INTR_TEST_OFFSET, 32'h0, "intr_test");
	read_expect(UART_CTRL_OFFSET, 32'h0, "ctrl");
	read_expect(UART_STATUS_OFFSET, 32'h0, "status");
	read_expect(UART_RDATA_OFFSET, 32'h0, "rdata");
	read_expect(UART_WDATA_OFFSET, 32'h0, "wdata");
	read_expect(UART_FIFO_CTRL_OFFSET, 32'h0, "fifo_ctrl");
	report_test("after_reset_defaults", errs);
endtask

task automatic ctrl_write_read();
	int errs;
	logic [31:0] word;
	logic err;
	errs = err_cnt;
	for (int i = 0; i < 8; i++) begin
		word = $random(seed);
		bus_write(UART_CTRL_OFFSET, word, 4'b1111, err);
		check_value("ctrl write error", 64'(err), 64'h0);
		check_value("ctrl_reg2hw_o.tx", 64'(ctrl_r2h.tx), 64'(word[0]));
		check_value("ctrl_reg2hw_o.rx", 64'(ctrl_r2h.rx), 64'(word[1]));
		check_value("ctrl_reg2hw_o.nf", 64'(ctrl_r2h.nf), 64'(word[2]));
		check_value("ctrl_reg2hw_o.slpbk", 64'(ctrl_r2h.slpbk), 64'(word[4]));
		check_value("ctrl_reg2hw_o.llpbk", 64'(ctrl_r2h.llpbk), 64'(word[5]));
		check_value("ctrl_reg2hw_o.parity_en", 64'(ctrl_r2h.parity_en), 64'(word[6]));
		check_value("ctrl_reg2hw_o.parity_odd", 64'(ctrl_r2h.parity_odd), 64'(word[7]));
		check_value("ctrl_reg2hw_o.rxblvl", 64'(ctrl_r2h.rxblvl), 64'(word[9:8]));
		check_value("ctrl_reg2hw_o.nco", 64'(ctrl_r2h.nco), 64'(word[31:16]));
		read_expect(UART_CTRL_OFFSET, word & ~CTRL_RSVD_MASK, "ctrl");
	end
	ctrl_shadow = word & ~CTRL_RSVD_MASK;
	// partial byte enables must be refused.
	bus_write(UART_CTRL_OFFSET, ~word, 4'b0111, err);
	check_value("ctrl partial write error", 64'(err), 64'h1);
	read_expect(UART_CTRL_OFFSET, ctrl_shadow, "ctrl after partial write");
	report_test("ctrl_write_read", errs);
endtask

task automatic interrupt_fields();
	int errs;
	logic [31:0] rnd;
	logic err;
	errs = err_cnt;
	// rx_overflow is bit 3.
	intr_hw.d = 8'h08;
	intr_hw.de = 8'h08;
	next_cycle();
	intr_hw = '0;
	read_expect(UART_INTR_STATE_OFFSET, 32'h08, "intr_state after hw set");
	check_value("intr_reg2hw_o.state", 64'(intr_r2h.state), 64'h08);
	bus_write(UART_INTR_STATE_OFFSET, 32'h0, 4'b0001, err);
	read_expect(UART_INTR_STATE_OFFSET, 32'h08, "intr_state after writing 0");
	bus_write(UART_INTR_STATE_OFFSET, 32'h08, 4'b0001, err);
	read_expect(UART_INTR_STATE_OFFSET, 32'h0, "intr_state after W1C");
	// set and clear on the same edge.
	intr_hw.d = 8'h81;
	intr_hw.de = 8'h81;
	bus_write(UART_INTR_STATE_OFFSET, 32'h81, 4'b0001, err);
	intr_hw = '0;
	read_expect(UART_INTR_STATE_OFFSET, 32'h81, "intr_state after set with clear");
	bus_write(UART_INTR_STATE_OFFSET, 32'hff, 4'b0001, err);
	read_expect(UART_INTR_STATE_OFFSET, 32'h0, "intr_state after clearing all");
	rnd = $random(seed);
	enable_shadow = rnd[7:0];
	bus_write(UART_INTR_ENABLE_OFFSET, rnd, 4'b0001, err);
	read_expect(UART_INTR_ENABLE_OFFSET, {24'h0, enable_shadow}, "intr_enable");
	check_value("intr_reg2hw_o.enable", 64'(intr_r2h.enable), 64'(enable_shadow));
	rnd = $random(seed);
	bus_write(UART_INTR_TEST_OFFSET, rnd, 4'b0001, err);
	check_value("intr_reg2hw_o.test_qe in write cycle", 64'(intr_snap.test_qe), 64'h1);
	check_value("intr_reg2hw_o.test in write cycle", 64'(intr_snap.test), 64'(rnd[7:0]));
	read_expect(UART_INTR_TEST_OFFSET, 32'h0, "intr_test");
	check_value("intr_reg2hw_o.test_qe after write", 64'(intr_snap.test_qe), 64'h0);
	read_expect(UART_INTR_STATE_OFFSET, 32'h0, "intr_state after test write");
	report_test("interrupt_fields", errs);
endtask

task automatic pulse_fields();
	int errs;
	logic [31:0] rnd;
	logic err;
	errs = err_cnt;
	rnd = $random(seed);
	bus_write(UART_WDATA_OFFSET, rnd, 4'b0001, err);
	check_value("wdata_qe in write cycle", 64'(ctrl_snap.wdata_qe), 64'h0);
	check_value("wdata_qe after write", 64'(ctrl_r2h.wdata_qe), 64'h1);
	check_value("ctrl_reg2hw_o.wdata", 64'(ctrl_r2h.wdata), 64'(rnd[7:0]));
	next_cycle();
	check_value("wdata_qe one cycle later", 64'(ctrl_r2h.wdata_qe), 64'h0);
	read_expect(UART_WDATA_OFFSET, 32'h0, "wdata");
	bus_write(UART_FIFO_CTRL_OFFSET, fifo_ctrl_word(1'b1, 1'b1, 3'd5, 2'd2), 4'b0001, err);
	check_value("rxrst_qe after write", 64'(ctrl_r2h.rxrst_qe), 64'h1);
	check_value("txrst_qe after write", 64'(ctrl_r2h.txrst_qe), 64'h1);
	check_value("ctrl_reg2hw_o.rxrst", 64'(ctrl_r2h.rxrst), 64'h1);
	check_value("ctrl_reg2hw_o.txrst", 64'(ctrl_r2h.txrst), 64'h1);
	next_cycle();
	check_value("rxrst_qe one cycle later", 64'(ctrl_r2h.rxrst_qe), 64'h0);
	check_value("txrst_qe one cycle later", 64'(ctrl_r2h.txrst_qe), 64'h0);
	read_expect(UART_FIFO_CTRL_OFFSET, fifo_ctrl_word(1'b0, 1'b0, 3'd5, 2'd2), "fifo_ctrl");
	check_value("ctrl_reg2hw_o.rxilvl", 64'(ctrl_r2h.rxilvl), 64'd5);
	check_value("ctrl_reg2hw_o.txilvl", 64'(ctrl_r2h.txilvl), 64'd2);
	// hardware load against a software write.
	ctrl_hw.rxilvl = 3'd2;
	ctrl_hw.rxilvl_de = 1'b1;
	ctrl_hw.txilvl = 2'd1;
	ctrl_hw.txilvl_de = 1'b1;
	bus_write(UART_FIFO_CTRL_OFFSET, fifo_ctrl_word(1'b0, 1'b0, 3'd7, 2'd3), 4'b0001, err);
	ctrl_hw.rxilvl_de = 1'b0;
	ctrl_hw.txilvl_de = 1'b0;
	read_expect(UART_FIFO_CTRL_OFFSET, fifo_ctrl_word(1'b0, 1'b0, 3'd2, 2'd1),
		"fifo_ctrl after hw load");
	report_test("pulse_fields", errs);
endtask

task automatic status_rdata_reads();
	int errs;
	logic [31:0] rnd;
	errs = err_cnt;
	rnd = $random(seed);
	ctrl_hw.status = rnd[5:0];
	ctrl_hw.rdata = rnd[15:8];
	read_expect(UART_STATUS_OFFSET, {26'h0, rnd[5:0]}, "status");
	check_value("status_re in read cycle", 64'(ctrl_snap.status_re), 64'h1);
	check_value("rdata_re in status read", 64'(ctrl_snap.rdata_re), 64'h0);
	read_expect(UART_RDATA_OFFSET, {24'h0, rnd[15:8]}, "rdata");
	check_value("rdata_re in read cycle", 64'(ctrl_snap.rdata_re), 64'h1);
	check_value("status_re in rdata read", 64'(ctrl_snap.status_re), 64'h0);
	ctrl_hw.status = '0;
	ctrl_hw.rdata = '0;
	report_test("status_rdata_reads", errs);
endtask

task automatic unmapped_access();
	int errs;
	logic [5:0] addrs [3] = '{6'h20, 6'h2c, 6'h3c};
	logic [31:0] rd;
	logic err;
	errs = err_cnt;
	// a pending bit that a stray W1C would clear.
	intr_hw.d = 8'h10;
	intr_hw.de = 8'h10;
	next_cycle();
	intr_hw = '0;
	for (int i = 0; i < 3; i++) begin
		bus_read(addrs[i], rd, err);
		check_value("unmapped read rdata", 64'(rd), 64'hffff_ffff);
		check_value("unmapped read error", 64'(err), 64'h1);
		bus_write(addrs[i], 32'hffff_ffff, 4'b1111, err);
		check_value("unmapped write error", 64'(err), 64'h1);
		check_value("wdata_qe after unmapped write", 64'(ctrl_r2h.wdata_qe), 64'h0);
		check_value("rxrst_qe after unmapped write", 64'(ctrl_r2h.rxrst_qe), 64'h0);
	end
	read_expect(UART_CTRL_OFFSET, ctrl_shadow, "ctrl after unmapped writes");
	read_expect(UART_INTR_ENABLE_OFFSET, {24'h0, enable_shadow}, "intr_enable unchanged");
	read_expect(UART_INTR_STATE_OFFSET, 32'h10, "intr_state unchanged");
	read_expect(UART_FIFO_CTRL_OFFSET, fifo_ctrl_word(1'b0, 1'b0, 3'd2, 2'd1),
		"fifo_ctrl unchanged");
	report_test("unmapped_access", errs);
endtask

// ==== sim/uart_reg_tb.sv ====
`timescale 1ns/1ps

module uart_reg_tb;
	import uart_reg_pkg::*;

	// the tests take about 70 cycles.
	localparam int MAX_CYCLES = 2000;
	// ctrl bit 3 and bits 15:10 are reserved.
	localparam logic [31:0] CTRL_RSVD_MASK = 32'h0000_fc08;

	logic clk = 1'b0;
	logic rst_n;
	uart_reg_req_t bus_req;
	uart_reg_rsp_t bus_rsp;
	uart_intr_hw2reg_t intr_hw;
	uart_intr_reg2hw_t intr_r2h;
	uart_ctrl_hw2reg_t ctrl_hw;
	uart_ctrl_reg2hw_t ctrl_r2h;

	// reg2hw as seen in the strobe cycle of the last access.
	uart_intr_reg2hw_t intr_snap;
	uart_ctrl_reg2hw_t ctrl_snap;

	logic [31:0] ctrl_shadow;
	logic [7:0] enable_shadow;

	int seed = 32'h7121fb6c;
	int cycle_cnt = 0;
	int check_cnt = 0;
	int err_cnt = 0;

	uart_reg_top i_dut (
		.clk_i (clk),
		.rst_n_i (rst_n),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.intr_hw2reg_i (intr_hw),
		.intr_reg2hw_o (intr_r2h),
		.ctrl_hw2reg_i (ctrl_hw),
		.ctrl_reg2hw_o (ctrl_r2h)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		check_cnt++;
		assert (got === exp) else begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// fifo_ctrl word from its fields.
	function automatic logic [31:0] fifo_ctrl_word(input logic rxrst, input logic txrst,
			input logic [2:0] rxilvl, input logic [1:0] txilvl);
		return {25'h0, txilvl, rxilvl, txrst, rxrst};
	endfunction

	task automatic bus_write(input logic [5:0] addr, input logic [31:0] data,
			input logic [3:0] be, output logic err);
		bus_req.we = 1'b1;
		bus_req.re = 1'b0;
		bus_req.addr = addr;
		bus_req.wdata = data;
		bus_req.be = be;
		#3;
		err = bus_rsp.error;
		intr_snap = intr_r2h;
		ctrl_snap = ctrl_r2h;
		next_cycle();
		bus_req = '0;
	endtask

	task automatic bus_read(input logic [5:0] addr, output logic [31:0] data,
			output logic err);
		bus_req.we = 1'b0;
		bus_req.re = 1'b1;
		bus_req.addr = addr;
		bus_req.wdata = '0;
		bus_req.be = 4'b1111;
		#3;
		data = bus_rsp.rdata;
		err = bus_rsp.error;
		intr_snap = intr_r2h;
		ctrl_snap = ctrl_r2h;
		next_cycle();
		bus_req = '0;
	endtask

	task automatic read_expect(input logic [5:0] addr, input logic [31:0] exp,
			input string name);
		logic [31:0] data;
		logic err;
		bus_read(addr, data, err);
		check_value({name, " rdata"}, 64'(data), 64'(exp));
		check_value({name, " error"}, 64'(err), 64'h0);
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s finished with %0d errors", name, err_cnt - errs_before);
	endtask

	`include "uart_reg_tests.svh"

	initial begin
		bus_req = '0;
		intr_hw = '0;
		ctrl_hw = '0;
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		next_cycle();
		after_reset_defaults();
		ctrl_write_read();
		interrupt_fields();
		pulse_fields();
		status_rdata_reads();
		unmapped_access();
		$display("%0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== uart_reg_top.f ====
+incdir+sim
common/uart_reg_pkg.sv
source/uart_reg_decode.sv
source/uart_reg_readback.sv
source/uart_intr_regs.sv
source/uart_ctrl_regs.sv
source/uart_reg_top.sv
sim/uart_reg_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = uart_reg_tb
FILELIST = uart_reg_top.f
PASS_MSG = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
